// ==== Bender.yml ====
package:
  name: softmax_mem

sources:
  - include_dirs:
      - .
    files:
      - softmax_mem_pkg.sv
      - softmax_config.sv
      - read_master.sv
      - write_master.sv
      - mem_arbiter.sv
      - softmax_dp_mem.sv
      - softmax_mem_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_avl_mem.sv
      - tb_softmax_mem.sv

// ==== mem_arbiter.sv ====
// round-robin arbiter for the shared external memory bus
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire softmax_mem_pkg::mem_req_t rd_req,
    output softmax_mem_pkg::mem_rsp_t      rd_rsp,
    input  wire softmax_mem_pkg::mem_req_t wr_req,
    output softmax_mem_pkg::mem_rsp_t      wr_rsp,
    output softmax_mem_pkg::mem_req_t      mem_req,
    input  wire softmax_mem_pkg::mem_rsp_t mem_rsp
);
    import softmax_mem_pkg::*;

    logic rd_v;
    logic wr_v;
    logic gnt;      // 0 read master, 1 write master
    logic gnt_q;
    logic lock;     // granted request still held by waitrequest
    logic rr;       // master with priority next
    logic cur_v;

    assign rd_v  = rd_req.read || rd_req.write;
    assign wr_v  = wr_req.read || wr_req.write;
    assign gnt   = lock ? gnt_q : ((rd_v && wr_v) ? rr : wr_v);
    assign cur_v = gnt ? wr_v : rd_v;

    assign mem_req = gnt ? wr_req : rd_req;

    assign rd_rsp.waitrequest   = mem_rsp.waitrequest || gnt;
    assign rd_rsp.readdatavalid = mem_rsp.readdatavalid;  // reads only come from here
    assign rd_rsp.readdata      = mem_rsp.readdata;
    assign wr_rsp.waitrequest   = mem_rsp.waitrequest || !gnt;
    assign wr_rsp.readdatavalid = 1'b0;
    assign wr_rsp.readdata      = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock  <= 1'b0;
            gnt_q <= 1'b0;
            rr    <= 1'b0;
        end else begin
            lock  <= cur_v && mem_rsp.waitrequest;
            gnt_q <= gnt;
            if (cur_v && !mem_rsp.waitrequest)
                rr <= !gnt;  // other master first next time
        end
    end

endmodule

`default_nettype wire

// ==== read_master.sv ====
// read master with pipelined reads and a show-ahead beat FIFO
`timescale 1ns/10ps
`default_nettype none
`include "softmax_mem_settings.svh"

module read_master (
    input  wire softmax_mem_pkg::master_cmd_t cmd,
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    output logic                              done,
    input  wire logic                         read_buffer,
    output logic      [`SM_XDW-1:0]           buffer_data,
    output logic                              data_available,
    output softmax_mem_pkg::mem_req_t         mem_req,
    input  wire softmax_mem_pkg::mem_rsp_t    mem_rsp
);
    import softmax_mem_pkg::*;

    localparam int PW = $clog2(`SM_FIFO_DEPTH);
    localparam logic [PW:0] DEPTH = `SM_FIFO_DEPTH;

    logic [`SM_XDW-1:0]  fifo [`SM_FIFO_DEPTH];
    logic [PW-1:0]       wptr;
    logic [PW-1:0]       rptr;
    logic [PW:0]         fcount;      // beats held
    logic [PW:0]         used;        // beats held plus reads in flight
    logic [`SM_XAW-5:0]  issue_left;
    logic [`SM_XAW-5:0]  rtn_left;
    logic [`SM_XAW-1:0]  addr;
    logic                accept;
    logic                push;
    logic                pop;

    // used only falls while waiting, so the request stays up until accepted
    assign mem_req.read      = (issue_left != '0) && (used < DEPTH);
    assign mem_req.write     = 1'b0;
    assign mem_req.address   = addr;
    assign mem_req.writedata = '0;

    assign accept         = mem_req.read && !mem_rsp.waitrequest;
    assign push           = mem_rsp.readdatavalid;
    assign pop            = read_buffer && data_available;
    assign data_available = (fcount != '0);
    assign buffer_data    = fifo[rptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr       <= '0;
            rptr       <= '0;
            fcount     <= '0;
            used       <= '0;
            issue_left <= '0;
            rtn_left   <= '0;
            done       <= 1'b0;
        end else begin
            done <= push && (rtn_left == 1);  // last beat back
            if (cmd.go) begin
                issue_left <= cmd.length[`SM_XAW-1:4];
                rtn_left   <= cmd.length[`SM_XAW-1:4];
            end else begin
                if (accept)
                    issue_left <= issue_left - 1'b1;
                if (push)
                    rtn_left <= rtn_left - 1'b1;
            end
            if (push)
                wptr <= wptr + 1'b1;
            if (pop)
                rptr <= rptr + 1'b1;
            fcount <= fcount + push - pop;
            used   <= used + accept - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.go)
            addr <= cmd.base;
        else if (accept)
            addr <= addr + `SM_XAW'(16);  // one beat
        if (push)
            fifo[wptr] <= mem_rsp.readdata;
    end

endmodule

`default_nettype wire

// ==== softmax_config.sv ====
// configuration registers, start pulse and status register
`timescale 1ns/10ps
`default_nettype none
`include "softmax_mem_settings.svh"

module softmax_config (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              config_ena,
    input  wire logic [`SM_CW-1:0] config_addr,
    input  wire logic [`SM_DW-1:0] config_wdata,
    output logic      [`SM_DW-1:0] config_rdata,
    output logic                   config_done,
    output logic      [`SM_XAW-1:0] param_raddr,
    output logic      [`SM_XAW-1:0] param_waddr,
    output logic      [`SM_AW:0]   param_iolen,
    input  wire logic              load_data_done,
    input  wire logic              store_data_done
);
    import softmax_mem_pkg::*;

    logic [STAT_W-1:0] status;
    logic              start;

    // a start while busy is dropped
    assign start = config_ena && (cfg_addr_e'(config_addr) == CFG_START) &&
                   config_wdata[0] && !status[STAT_BUSY];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            param_raddr <= '0;
            param_waddr <= '0;
            param_iolen <= '0;
            status      <= '0;
            config_done <= 1'b0;
        end else begin
            config_done <= start;
            if (config_ena && !status[STAT_BUSY]) begin  // job parameters frozen while busy
                case (cfg_addr_e'(config_addr))
                    CFG_RADDR: param_raddr <= config_wdata;
                    CFG_WADDR: param_waddr <= config_wdata;
                    CFG_IOLEN: param_iolen <= config_wdata[`SM_AW:0];
                    default: ;
                endcase
            end
            if (start) begin
                status            <= '0;    // new job clears loaded and stored
                status[STAT_BUSY] <= 1'b1;
            end else begin
                if (load_data_done)
                    status[STAT_LOADED] <= 1'b1;
                if (store_data_done) begin
                    status[STAT_STORED] <= 1'b1;
                    status[STAT_BUSY]   <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (cfg_addr_e'(config_addr))
            CFG_RADDR:  config_rdata = param_raddr;
            CFG_WADDR:  config_rdata = param_waddr;
            CFG_IOLEN:  config_rdata = `SM_DW'(param_iolen);
            CFG_STATUS: config_rdata = `SM_DW'(status);
            default:    config_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== softmax_dp_mem.sv ====
// load/store sequencer and banked local buffer with beat unpacking and packing
`timescale 1ns/10ps
`default_nettype none
`include "softmax_mem_settings.svh"

module softmax_dp_mem (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    config_done,
    input  wire logic [`SM_XAW-1:0]      param_raddr,
    input  wire logic [`SM_XAW-1:0]      param_waddr,
    input  wire logic [`SM_AW:0]         param_iolen,
    output softmax_mem_pkg::master_cmd_t rd_cmd,
    input  wire logic                    rd_done,
    output logic                         read_buffer,
    input  wire logic [`SM_XDW-1:0]      buffer_data,
    input  wire logic                    data_available,
    output softmax_mem_pkg::master_cmd_t wr_cmd,
    input  wire logic                    wr_done,
    output logic                         write_buffer,
    output logic      [`SM_XDW-1:0]      write_data,
    input  wire logic                    buffer_full,
    input  wire logic [`SM_AW-1:0]       core_addr,
    input  wire logic                    core_we,
    input  wire logic [`SM_DW-1:0]       core_wdata,
    output logic      [`SM_DW-1:0]       core_rdata,
    input  wire logic                    core_done,
    output logic                         load_data_done,
    output logic                         store_data_done
);
    import softmax_mem_pkg::*;

    localparam int WB = $clog2(`SM_WCNT);  // word select bits
    localparam int RW = `SM_AW - WB;       // beat row bits

    // one row per beat with word i in bits 32i up
    logic [`SM_WCNT-1:0][`SM_DW-1:0] buf_mem [2**RW];

    dp_state_e          state;
    logic [RW:0]        cnt;        // beats moved in this phase
    logic [RW:0]        nbeats;
    logic [`SM_XAW-1:0] len_bytes;
    logic               rd_go;
    logic               wr_go;
    logic               rd_seen;    // read master reported done
    logic               last_beat;

    assign nbeats    = param_iolen[`SM_AW:WB];
    assign len_bytes = `SM_XAW'({param_iolen, 2'b00});
    assign last_beat = (cnt == nbeats - 1'b1);

    assign rd_cmd = '{go: rd_go, base: param_raddr, length: len_bytes};
    assign wr_cmd = '{go: wr_go, base: param_waddr, length: len_bytes};

    assign read_buffer  = (state == LOAD) && data_available;
    assign write_buffer = (state == STORE) && !buffer_full && (cnt != nbeats);
    assign write_data   = buf_mem[cnt[RW-1:0]];  // whole row packs into one beat

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= IDLE;
            cnt             <= '0;
            rd_go           <= 1'b0;
            wr_go           <= 1'b0;
            rd_seen         <= 1'b0;
            load_data_done  <= 1'b0;
            store_data_done <= 1'b0;
        end else begin
            rd_go           <= 1'b0;
            wr_go           <= 1'b0;
            load_data_done  <= 1'b0;
            store_data_done <= 1'b0;
            if (rd_done)
                rd_seen <= 1'b1;
            case (state)
                IDLE: if (config_done) begin
                    rd_go   <= 1'b1;
                    rd_seen <= 1'b0;
                    cnt     <= '0;
                    state   <= LOAD;
                end
                LOAD: if (read_buffer) begin
                    cnt <= cnt + 1'b1;
                    // done may arrive in the same cycle as the last pop
                    if (last_beat && (rd_seen || rd_done)) begin
                        load_data_done <= 1'b1;
                        state          <= WAIT_CORE;
                    end
                end
                WAIT_CORE: if (core_done) begin
                    wr_go <= 1'b1;
                    cnt   <= '0;
                    state <= STORE;
                end
                STORE: begin
                    if (write_buffer)
                        cnt <= cnt + 1'b1;
                    if (wr_done) begin  // last write accepted and FIFO drained
                        store_data_done <= 1'b1;
                        state           <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (read_buffer)
            buf_mem[cnt[RW-1:0]] <= buffer_data;
        else if ((state == WAIT_CORE) && core_we)
            buf_mem[core_addr[`SM_AW-1:WB]][core_addr[WB-1:0]] <= core_wdata;
        core_rdata <= buf_mem[core_addr[`SM_AW-1:WB]][core_addr[WB-1:0]];
    end

endmodule

`default_nettype wire

// ==== softmax_mem.f ====
+incdir+.
softmax_mem_pkg.sv
softmax_config.sv
read_master.sv
write_master.sv
mem_arbiter.sv
softmax_dp_mem.sv
softmax_mem_top.sv
tb_avl_mem.sv
tb_softmax_mem.sv

// ==== softmax_mem_pkg.sv ====
// memory bus and master command structs, sequencer and config enums, status bits
`default_nettype none
`include "softmax_mem_settings.svh"

package softmax_mem_pkg;

    typedef struct packed {
        logic               read;
        logic               write;
        logic [`SM_XAW-1:0] address;   // byte address
        logic [`SM_XDW-1:0] writedata;
    } mem_req_t;

    typedef struct packed {
        logic               waitrequest;
        logic               readdatavalid;
        logic [`SM_XDW-1:0] readdata;
    } mem_rsp_t;

    typedef struct packed {
        logic               go;       // one cycle start
        logic [`SM_XAW-1:0] base;     // byte address
        logic [`SM_XAW-1:0] length;   // bytes
    } master_cmd_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        WAIT_CORE,
        STORE
    } dp_state_e;

    typedef enum logic [`SM_CW-1:0] {
        CFG_RADDR  = 6'h00,
        CFG_WADDR  = 6'h01,
        CFG_IOLEN  = 6'h02,
        CFG_START  = 6'h20,
        CFG_STATUS = 6'h21
    } cfg_addr_e;

    // status register bit positions
    localparam int STAT_BUSY   = 0;
    localparam int STAT_LOADED = 1;
    localparam int STAT_STORED = 2;
    localparam int STAT_W      = 3;

endpackage

`default_nettype wire

// ==== softmax_mem_settings.svh ====
// width, depth and FIFO size defines for the softmax memory side
`ifndef SOFTMAX_MEM_SETTINGS_SVH
`define SOFTMAX_MEM_SETTINGS_SVH

// internal word width
`define SM_DW 32
// external memory beat width
`define SM_XDW 128
// external byte address width
`define SM_XAW 32
// internal words per external beat
`define SM_WCNT 4
// local buffer word address width
`define SM_AW 12
// configuration address width
`define SM_CW 6
// beat FIFO depth inside each master
`define SM_FIFO_DEPTH 4

`endif

// ==== softmax_mem_top.sv ====
// top level with config block, sequencer, both masters and the bus arbiter
`timescale 1ns/10ps
`default_nettype none
`include "softmax_mem_settings.svh"

module softmax_mem_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      config_ena,
    input  wire logic [`SM_CW-1:0]         config_addr,
    input  wire logic [`SM_DW-1:0]         config_wdata,
    output logic      [`SM_DW-1:0]         config_rdata,
    output logic                           config_done,
    input  wire logic [`SM_AW-1:0]         core_addr,
    input  wire logic                      core_we,
    input  wire logic [`SM_DW-1:0]         core_wdata,
    output logic      [`SM_DW-1:0]         core_rdata,
    input  wire logic                      core_done,
    output logic                           load_data_done,
    output logic                           store_data_done,
    output softmax_mem_pkg::mem_req_t      mem_req,
    input  wire softmax_mem_pkg::mem_rsp_t mem_rsp
);
    import softmax_mem_pkg::*;

    logic [`SM_XAW-1:0] param_raddr;
    logic [`SM_XAW-1:0] param_waddr;
    logic [`SM_AW:0]    param_iolen;
    master_cmd_t        rd_cmd;
    master_cmd_t        wr_cmd;
    logic               rd_done;
    logic               wr_done;
    logic               read_buffer;
    logic [`SM_XDW-1:0] buffer_data;
    logic               data_available;
    logic               write_buffer;
    logic [`SM_XDW-1:0] write_data;
    logic               buffer_full;
    mem_req_t           rd_req;
    mem_rsp_t           rd_rsp;
    mem_req_t           wr_req;
    mem_rsp_t           wr_rsp;

    softmax_config softmax_config_inst (
        .clk, .rst_n, .config_ena, .config_addr, .config_wdata, .config_rdata,
        .config_done, .param_raddr, .param_waddr, .param_iolen,
        .load_data_done, .store_data_done
    );

    softmax_dp_mem softmax_dp_mem_inst (
        .clk, .rst_n, .config_done, .param_raddr, .param_waddr, .param_iolen,
        .rd_cmd, .rd_done, .read_buffer, .buffer_data, .data_available,
        .wr_cmd, .wr_done, .write_buffer, .write_data, .buffer_full,
        .core_addr, .core_we, .core_wdata, .core_rdata, .core_done,
        .load_data_done, .store_data_done
    );

    read_master read_master_inst (
        .clk, .rst_n, .cmd(rd_cmd), .done(rd_done), .read_buffer, .buffer_data,
        .data_available, .mem_req(rd_req), .mem_rsp(rd_rsp)
    );

    write_master write_master_inst (
        .clk, .rst_n, .cmd(wr_cmd), .done(wr_done), .write_buffer, .write_data,
        .buffer_full, .mem_req(wr_req), .mem_rsp(wr_rsp)
    );

    mem_arbiter mem_arbiter_inst (
        .clk, .rst_n, .rd_req, .rd_rsp, .wr_req, .wr_rsp, .mem_req, .mem_rsp
    );

endmodule

`default_nettype wire

// ==== tb_avl_mem.sv ====
// external memory model with random waitrequest and in-order reads of variable latency
`timescale 1ns/10ps
`default_nettype none
`include "softmax_mem_settings.svh"

module tb_avl_mem (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire softmax_mem_pkg::mem_req_t mem_req,
    output softmax_mem_pkg::mem_rsp_t      mem_rsp
);
    import softmax_mem_pkg::*;

    logic [`SM_XDW-1:0] beats [int unsigned];  // written beats by beat index
    logic [`SM_XDW-1:0] rd_data_q [$];
    int unsigned        rd_due_q [$];          // cycle from which the beat may return
    int unsigned        cyc;

    // words never written read back as a scramble of their byte address
    function automatic logic [`SM_DW-1:0] fill_word(input logic [`SM_XAW-1:0] a);
        return (a * 32'h9E37_79B1) ^ 32'hA5C3_0F1E;
    endfunction

    // current content of the word at byte address a
    function automatic logic [`SM_DW-1:0] peek_word(input logic [`SM_XAW-1:0] a);
        int unsigned        key;
        logic [`SM_XDW-1:0] beat;
        key = a >> 4;
        if (!beats.exists(key))
            return fill_word(a);
        beat = beats[key];
        return beat[32 * a[3:2] +: 32];
    endfunction

    function automatic logic [`SM_XDW-1:0] read_beat(input logic [`SM_XAW-1:0] a);
        logic [`SM_XDW-1:0] beat;
        int                 i;
        for (i = 0; i < `SM_WCNT; i++)
            beat[32 * i +: 32] = peek_word({a[`SM_XAW-1:4], 4'h0} + 4 * i);
        return beat;
    endfunction

    initial begin
        mem_rsp <= '0;
        cyc     = 0;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_req.read && !mem_rsp.waitrequest) begin
                rd_data_q.push_back(read_beat(mem_req.address));
                rd_due_q.push_back(cyc + ($urandom % 4) + 1);  // 1 to 4 cycles
            end
            if (mem_req.write && !mem_rsp.waitrequest)
                beats[mem_req.address >> 4] = mem_req.writedata;
        end
        cyc = cyc + 1;
    end

    always @(negedge clk) begin
        mem_rsp.readdatavalid <= 1'b0;
        mem_rsp.readdata      <= '0;
        if (!rst_n) begin
            mem_rsp.waitrequest <= 1'b0;
            rd_data_q.delete();
            rd_due_q.delete();
        end else begin
            mem_rsp.waitrequest <= (($urandom % 3) == 0);
            if ((rd_due_q.size() != 0) && (rd_due_q[0] <= cyc)) begin  // only the head may return
                mem_rsp.readdatavalid <= 1'b1;
                mem_rsp.readdata      <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_softmax_mem.sv ====
// testbench top with clock, reset, config and core models, bus monitor and watchdog
`timescale 1ns/10ps
`default_nettype none
`include "softmax_mem_settings.svh"

module tb_softmax_mem;
    import softmax_mem_pkg::*;

    localparam int TOTAL_WORDS  = 48;  // both jobs together
    localparam int LIMIT_CYCLES = 2000 + 200 * TOTAL_WORDS;

    logic               clk;
    logic               rst_n;
    logic               config_ena;
    logic [`SM_CW-1:0]  config_addr;
    logic [`SM_DW-1:0]  config_wdata;
    logic [`SM_DW-1:0]  config_rdata;
    logic               config_done;
    logic [`SM_AW-1:0]  core_addr;
    logic               core_we;
    logic [`SM_DW-1:0]  core_wdata;
    logic [`SM_DW-1:0]  core_rdata;
    logic               core_done;
    logic               load_data_done;
    logic               store_data_done;
    mem_req_t           mem_req;
    mem_rsp_t           mem_rsp;

    int                 checks;
    int                 errors;
    int                 done_pulses;
    int                 store_pulses;
    logic [`SM_XAW-1:0] rd_lo;
    logic [`SM_XAW-1:0] rd_hi;
    logic [`SM_XAW-1:0] wr_lo;
    logic [`SM_XAW-1:0] wr_hi;
    logic [`SM_DW-1:0]  exp_load [2**`SM_AW];  // source words seen before the job
    mem_req_t           req_q;
    logic               held_q;
    logic [`SM_DW-1:0]  rd;

    softmax_mem_top softmax_mem_top_inst (
        .clk, .rst_n, .config_ena, .config_addr, .config_wdata, .config_rdata,
        .config_done, .core_addr, .core_we, .core_wdata, .core_rdata, .core_done,
        .load_data_done, .store_data_done, .mem_req, .mem_rsp
    );

    tb_avl_mem tb_avl_mem_inst (.clk, .rst_n, .mem_req, .mem_rsp);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_equal(input string name, input logic [191:0] got,
                               input logic [191:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic write_config(input logic [`SM_CW-1:0] addr, input logic [`SM_DW-1:0] data);
        @(negedge clk);
        config_ena   = 1'b1;
        config_addr  = addr;
        config_wdata = data;
        @(negedge clk);
        config_ena   = 1'b0;
    endtask

    task automatic read_config(input logic [`SM_CW-1:0] addr, output logic [`SM_DW-1:0] data);
        @(negedge clk);
        config_ena  = 1'b0;
        config_addr = addr;
        @(posedge clk);
        data = config_rdata;
    endtask

    // core stand-in that adds each word's index to it
    task automatic serve_core(input int words);
        int                k;
        logic [`SM_DW-1:0] got;
        @(posedge clk);
        while (!load_data_done)
            @(posedge clk);
        for (k = 0; k < words; k++) begin
            @(negedge clk);
            core_we   = 1'b0;
            core_addr = k[`SM_AW-1:0];
            @(negedge clk);
            got = core_rdata;  // one cycle after the address
            check_equal("core_rdata", got, exp_load[k]);
            core_wdata = got + k;
            core_we    = 1'b1;
        end
        @(negedge clk);
        core_we   = 1'b0;
        core_done = 1'b1;
        @(negedge clk);
        core_done = 1'b0;
    endtask

    task automatic run_job(input logic [`SM_XAW-1:0] raddr, input logic [`SM_XAW-1:0] waddr,
                           input int words, input int job_no);
        int                k;
        logic [`SM_DW-1:0] st;
        for (k = 0; k < words; k++)
            exp_load[k] = tb_avl_mem_inst.peek_word(raddr + 4 * k);
        rd_lo = raddr;
        rd_hi = raddr + 4 * words;
        wr_lo = waddr;
        wr_hi = waddr + 4 * words;
        write_config(CFG_RADDR, raddr);
        write_config(CFG_WADDR, waddr);
        write_config(CFG_IOLEN, words);
        @(negedge clk);
        config_ena   = 1'b1;
        config_addr  = CFG_START;
        config_wdata = 32'h1;
        @(posedge clk);
        check_equal("config_done", config_done, 1'b0);
        @(negedge clk);
        config_ena = 1'b0;
        @(posedge clk);
        check_equal("config_done", config_done, 1'b1);  // exactly one cycle later
        fork
            serve_core(words);
            begin
                @(posedge clk);
                check_equal("config_done", config_done, 1'b0);
                read_config(CFG_STATUS, st);
                check_equal("status busy", st[STAT_BUSY], 1'b1);
                write_config(CFG_START, 32'h1);  // must be ignored
                repeat (3) begin
                    @(posedge clk);
                    check_equal("config_done", config_done, 1'b0);
                end
            end
        join
        @(posedge clk);
        while (!store_data_done)
            @(posedge clk);
        repeat (3) @(posedge clk);
        check_equal("store_data_done pulses", store_pulses, job_no);
        for (k = 0; k < words; k++)
            check_equal("mem word", tb_avl_mem_inst.peek_word(waddr + 4 * k), exp_load[k] + k);
        read_config(CFG_STATUS, st);
        check_equal("status", st, (1 << STAT_LOADED) | (1 << STAT_STORED));
    endtask

    // bus monitor at the external port
    always @(posedge clk) begin
        if (!rst_n) begin
            held_q <= 1'b0;
        end else begin
            if (held_q)
                check_equal("mem_req", mem_req, req_q);  // held request stays put
            if (mem_req.read && !mem_rsp.waitrequest) begin
                checks++;
                assert ((mem_req.address >= rd_lo) && (mem_req.address < rd_hi)) else begin
                    errors++;
                    $display("ERROR mem_req.address read 0x%0h outside 0x%0h to 0x%0h",
                             mem_req.address, rd_lo, rd_hi);
                end
            end
            if (mem_req.write && !mem_rsp.waitrequest) begin
                checks++;
                assert ((mem_req.address >= wr_lo) && (mem_req.address < wr_hi)) else begin
                    errors++;
                    $display("ERROR mem_req.address write 0x%0h outside 0x%0h to 0x%0h",
                             mem_req.address, wr_lo, wr_hi);
                end
            end
            if (config_done)
                done_pulses++;
            if (store_data_done)
                store_pulses++;
            held_q <= (mem_req.read || mem_req.write) && mem_rsp.waitrequest;
            req_q  <= mem_req;
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the jobs did not finish", LIMIT_CYCLES);
        $display("checks %0d errors %0d", checks, errors);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(73));
        checks       = 0;
        errors       = 0;
        done_pulses  = 0;
        store_pulses = 0;
        rd_lo        = '0;
        rd_hi        = '0;
        wr_lo        = '0;
        wr_hi        = '0;
        rst_n        = 1'b0;
        config_ena   = 1'b0;
        config_addr  = '0;
        config_wdata = '0;
        core_addr    = '0;
        core_we      = 1'b0;
        core_wdata   = '0;
        core_done    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_equal("config_done", config_done, 1'b0);
        check_equal("load_data_done", load_data_done, 1'b0);
        check_equal("store_data_done", store_data_done, 1'b0);
        check_equal("mem_req.read", mem_req.read, 1'b0);
        check_equal("mem_req.write", mem_req.write, 1'b0);
        read_config(CFG_STATUS, rd);
        check_equal("status", rd, 0);
        write_config(CFG_RADDR, 32'h1234_5670);
        read_config(CFG_RADDR, rd);
        check_equal("raddr", rd, 32'h1234_5670);
        write_config(CFG_WADDR, 32'h89AB_CDE0);
        read_config(CFG_WADDR, rd);
        check_equal("waddr", rd, 32'h89AB_CDE0);
        write_config(CFG_IOLEN, 32'd100);
        read_config(CFG_IOLEN, rd);
        check_equal("iolen", rd, 32'd100);
        run_job(32'h0000_1000, 32'h0000_4000, 16, 1);
        run_job(32'h0000_4020, 32'h0000_1000, 32, 2);  // reads part of job 1 output
        repeat (5) @(posedge clk);
        check_equal("config_done pulses", done_pulses, 2);
        check_equal("store_data_done pulses", store_pulses, 2);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== write_master.sv ====
// write master that queues user beats and writes them at incrementing addresses
`timescale 1ns/10ps
`default_nettype none
`include "softmax_mem_settings.svh"

module write_master (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire softmax_mem_pkg::master_cmd_t cmd,
    output logic                              done,
    input  wire logic                         write_buffer,
    input  wire logic [`SM_XDW-1:0]           write_data,
    output logic                              buffer_full,
    output softmax_mem_pkg::mem_req_t         mem_req,
    input  wire softmax_mem_pkg::mem_rsp_t    mem_rsp
);
    import softmax_mem_pkg::*;

    localparam int PW = $clog2(`SM_FIFO_DEPTH);
    localparam logic [PW:0] DEPTH = `SM_FIFO_DEPTH;

    logic [`SM_XDW-1:0]  fifo [`SM_FIFO_DEPTH];
    logic [PW-1:0]       wptr;
    logic [PW-1:0]       rptr;
    logic [PW:0]         fcount;
    logic [`SM_XAW-5:0]  write_left;  // beats not yet accepted
    logic [`SM_XAW-1:0]  addr;
    logic                push;
    logic                accept;

    assign buffer_full = (fcount == DEPTH);
    assign push        = write_buffer && !buffer_full;

    // head beat only moves on acceptance
    assign mem_req.read      = 1'b0;
    assign mem_req.write     = (fcount != '0) && (write_left != '0);
    assign mem_req.address   = addr;
    assign mem_req.writedata = fifo[rptr];

    assign accept = mem_req.write && !mem_rsp.waitrequest;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr       <= '0;
            rptr       <= '0;
            fcount     <= '0;
            write_left <= '0;
            done       <= 1'b0;
        end else begin
            done <= accept && (write_left == 1);
            if (cmd.go)
                write_left <= cmd.length[`SM_XAW-1:4];
            else if (accept)
                write_left <= write_left - 1'b1;
            if (push)
                wptr <= wptr + 1'b1;
            if (accept)
                rptr <= rptr + 1'b1;
            fcount <= fcount + push - accept;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.go)
            addr <= cmd.base;
        else if (accept)
            addr <= addr + `SM_XAW'(16);
        if (push)
            fifo[wptr] <= write_data;
    end

endmodule

`default_nettype wire
